// File: list.f
+incdir+hdl
hdl/leaf_pkg.sv
hdl/leaf_fifo.sv
hdl/leaf_rx.sv
hdl/leaf_tx.sv
hdl/leaf_interface.sv
hdl/user_kernel.sv
hdl/leaf_i3o6.sv
verification/leaf_tb.sv

// File: Bender.yml
package:
  name: leaf_i3o6

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/leaf_pkg.sv
      - hdl/leaf_fifo.sv
      - hdl/leaf_rx.sv
      - hdl/leaf_tx.sv
      - hdl/leaf_interface.sv
      - hdl/user_kernel.sv
      - hdl/leaf_i3o6.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/leaf_tb.sv

// File: verification/leaf_tb.sv
`include "leaf_cfg.svh"

module leaf_tb import leaf_pkg::*; ();

    localparam int                       NUM_OUT     = `LEAF_NUM_OUT_PORTS;
    localparam logic [`LEAF_ID_BITS-1:0] MY_LEAF     = 5'd3;
    localparam logic [`LEAF_ID_BITS-1:0] OTHER_LEAF  = 5'd4;
    localparam int                       DRAIN_LIMIT = 400;

    logic    clk;
    logic    rst_n;
    logic    resend;
    logic    ap_start;
    packet_t din;
    packet_t dout;
    integer  seed;
    logic    hung;
    string   hang_reason;

    route_t  route_model [NUM_OUT];   // routes as this testbench configured them.
    word_t   model_sum;
    word_t   model_cnt;
    packet_t exp_q [NUM_OUT][$];
    packet_t got_q [NUM_OUT][$];
    int      exp_count [NUM_OUT];
    int      rx_count [NUM_OUT];
    int      errors;
    int      err_base;
    int      tests_passed;
    int      tests_failed;

    leaf_i3o6 #(
        .LEAF_ID(MY_LEAF)
    ) leaf_i3o6_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .din_leaf_bft2interface (din),
        .dout_leaf_interface2bft(dout),
        .resend                 (resend),
        .ap_start               (ap_start)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // reference model and checks
    // ======================================================================

    function automatic packet_t kernel_ref(input int port, input word_t a, input word_t b,
                                           input word_t c, input word_t sum, input word_t cnt);
        packet_t p;
        p           = '0;
        p.vld       = 1'b1;
        p.dest_leaf = route_model[port - 1].leaf;
        p.dest_port = route_model[port - 1].port;
        p.addr      = `LEAF_ADDR_BITS'(port);
        case (port)
            1:       p.payload = a + b;
            2:       p.payload = a - b;
            3:       p.payload = (a > b) ? a : b;   // unsigned maximum.
            4:       p.payload = c;
            5:       p.payload = sum;
            default: p.payload = cnt;
        endcase
        return p;
    endfunction

    task automatic check_packet(input packet_t got, input packet_t want, input int port);
        if (got.vld !== want.vld) begin
            $display("FAIL dout.vld on port %0d: got 0x%h, expected 0x%h",
                     port, got.vld, want.vld);
            errors++;
        end
        if (got.dest_leaf !== want.dest_leaf) begin
            $display("FAIL dout.dest_leaf on port %0d: got 0x%h, expected 0x%h",
                     port, got.dest_leaf, want.dest_leaf);
            errors++;
        end
        if (got.dest_port !== want.dest_port) begin
            $display("FAIL dout.dest_port on port %0d: got 0x%h, expected 0x%h",
                     port, got.dest_port, want.dest_port);
            errors++;
        end
        if (got.addr !== want.addr) begin
            $display("FAIL dout.addr on port %0d: got 0x%h, expected 0x%h",
                     port, got.addr, want.addr);
            errors++;
        end
        if (got.payload !== want.payload) begin
            $display("FAIL dout.payload on port %0d: got 0x%h, expected 0x%h",
                     port, got.payload, want.payload);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", what, got, want);
            errors++;
        end
    endtask

    // collects every outbound packet at the falling edge, where dout is settled.
    always @(negedge clk) begin
        if (rst_n) begin
            if (resend && (dout !== '0)) begin
                $display("FAIL dout during resend: got 0x%h, expected 0x0", dout);
                errors++;
            end else if (dout !== '0) begin
                if ((dout.addr >= 1) && (dout.addr <= NUM_OUT)) begin
                    got_q[dout.addr - 1].push_back(dout);
                    rx_count[dout.addr - 1]++;
                end else begin
                    $display("outbound packet names addr %0d, which is no user port", dout.addr);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        packet_t got;
        packet_t want;
        for (int p = 0; p < NUM_OUT; p++) begin
            while ((got_q[p].size() > 0) && (exp_q[p].size() > 0)) begin
                got  = got_q[p].pop_front();
                want = exp_q[p].pop_front();
                check_packet(got, want, p + 1);
            end
        end
    end

    initial begin
        wait (hung === 1'b1);
        $display("%s", hang_reason);
        $display("TEST FAILED");
        $finish;
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (dout !== '0) begin
                $display("FAIL dout while idle: got 0x%h, expected 0x0", dout);
                errors++;
            end
            step();
        end
    endtask

    task automatic send(input logic [`LEAF_ID_BITS-1:0] leaf,
                        input logic [`LEAF_PORT_BITS-1:0] port,
                        input int addr, input word_t payload);
        packet_t p;
        p           = '0;
        p.vld       = 1'b1;
        p.dest_leaf = leaf;
        p.dest_port = port;
        p.addr      = `LEAF_ADDR_BITS'(addr);
        p.payload   = payload;
        din         = p;
        step();
        din = '0;
    endtask

    task automatic send_pair(input word_t a, input word_t b);
        send(MY_LEAF, 4'd1, 0, a);
        send(MY_LEAF, 4'd2, 0, b);
        for (int p = 1; p <= 3; p++) begin
            exp_q[p - 1].push_back(kernel_ref(p, a, b, '0, '0, '0));
            exp_count[p - 1]++;
        end
    endtask

    task automatic send_word(input word_t c);
        send(MY_LEAF, 4'd3, 0, c);
        model_sum = model_sum + c;
        model_cnt = model_cnt + 1;
        for (int p = 4; p <= NUM_OUT; p++) begin
            exp_q[p - 1].push_back(kernel_ref(p, '0, '0, c, model_sum, model_cnt));
            exp_count[p - 1]++;
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_OUT; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while ((pending() != 0) && (n < DRAIN_LIMIT)) begin
            step();
            n++;
        end
        if (pending() != 0) begin
            hang_reason = $sformatf("timeout: %0d expected packets never came out in test %s",
                                    pending(), what);
            hung = 1'b1;
            wait (hung === 1'b0);   // the watchdog ends the run.
        end
    endtask

    task automatic end_test(input string name);
        idle(6);   // room for a stray extra packet to show up.
        for (int p = 0; p < NUM_OUT; p++) begin
            check_count($sformatf("packets on port %0d", p + 1), rx_count[p], exp_count[p]);
            got_q[p].delete();
            rx_count[p] = exp_count[p];
        end
        if (errors == err_base) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic test_reset_start();
        word_t a [4];
        word_t b [4];
        word_t c [4];
        quiet_cycles(20);
        for (int k = 0; k < 2; k++) begin
            send(MY_LEAF, 4'd1, 0, $random(seed));   // the kernel is still held in reset.
            send(MY_LEAF, 4'd2, 0, $random(seed));
            send(MY_LEAF, 4'd3, 0, $random(seed));
        end
        quiet_cycles(20);
        ap_start = 1'b1;
        step();
        ap_start = 1'b0;
        for (int k = 0; k < 4; k++) begin
            a[k] = $random(seed);
            b[k] = $random(seed);
            c[k] = $random(seed);
            send(MY_LEAF, 4'd1, 0, a[k]);
        end
        for (int k = 0; k < 4; k++) begin
            send(MY_LEAF, 4'd2, 0, b[k]);
        end
        for (int k = 0; k < 4; k++) begin
            for (int p = 1; p <= 3; p++) begin
                exp_q[p - 1].push_back(kernel_ref(p, a[k], b[k], '0, '0, '0));
                exp_count[p - 1]++;
            end
            send_word(c[k]);
        end
        wait_drain("reset and ap_start");
        end_test("reset and ap_start");
    endtask

    task automatic test_pairs();
        route_t r;
        word_t  pl;
        for (int p = 1; p <= NUM_OUT; p++) begin
            r.leaf = `LEAF_ID_BITS'(8 + p);
            r.port = `LEAF_PORT_BITS'(p + 2);
            pl     = '0;
            pl[$bits(route_t)-1:0] = r;
            send(MY_LEAF, 4'd0, p, pl);
            route_model[p - 1] = r;
        end
        for (int k = 0; k < 20; k++) begin
            send_pair($random(seed), $random(seed));
            idle(4);
        end
        wait_drain("paired inputs");
        end_test("paired inputs");
    endtask

    task automatic test_stream();
        for (int k = 0; k < 20; k++) begin
            send_word($random(seed));
            idle(3);
        end
        wait_drain("stream input");
        end_test("stream input");
    endtask

    task automatic test_foreign();
        for (int p = 1; p <= NUM_OUT; p++) begin
            send(OTHER_LEAF, 4'd0, p, 32'hffff_ffff);
        end
        for (int p = 1; p <= 3; p++) begin
            send(OTHER_LEAF, `LEAF_PORT_BITS'(p), 0, $random(seed));
        end
        quiet_cycles(30);
        send_pair($random(seed), $random(seed));
        send_word($random(seed));
        wait_drain("foreign packets");
        end_test("foreign packets");
    endtask

    task automatic test_resend();
        for (int k = 0; k < 8; k++) begin
            send_pair($random(seed), $random(seed));
            send_word($random(seed));
            resend = 1'b1;
            idle(1 + ({$random(seed)} % 6));
            resend = 1'b0;
            idle(1 + ({$random(seed)} % 3));
            resend = 1'b1;
            idle(1 + ({$random(seed)} % 6));
            resend = 1'b0;
            wait_drain("resend");
        end
        end_test("resend");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        resend       = 1'b0;
        ap_start     = 1'b0;
        din          = '0;
        hung         = 1'b0;
        seed         = 32'h510e_327a;
        model_sum    = '0;
        model_cnt    = '0;
        errors       = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int p = 0; p < NUM_OUT; p++) begin
            route_model[p] = '0;   // the route table is zero after reset.
            exp_count[p]   = 0;
            rx_count[p]    = 0;
        end
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;

        test_reset_start();
        test_pairs();
        test_stream();
        test_foreign();
        test_resend();

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/leaf_i3o6.sv
`include "leaf_cfg.svh"

module leaf_i3o6 import leaf_pkg::*; #(
    parameter logic [`LEAF_ID_BITS-1:0] LEAF_ID = 5'd3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`LEAF_PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [`LEAF_PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  logic                         resend,
    input  logic                         ap_start
);

    word_t [`LEAF_NUM_IN_PORTS-1:0]  in_data;
    logic [`LEAF_NUM_IN_PORTS-1:0]   in_vld;
    logic [`LEAF_NUM_IN_PORTS-1:0]   in_ack;
    word_t [`LEAF_NUM_OUT_PORTS-1:0] out_data;
    logic [`LEAF_NUM_OUT_PORTS-1:0]  out_vld;
    logic [`LEAF_NUM_OUT_PORTS-1:0]  out_ack;
    logic                            user_rst_n;

    leaf_interface #(
        .LEAF_ID(LEAF_ID)
    ) leaf_interface_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_leaf_interface2bft),
        .resend                 (resend),
        .ap_start               (ap_start),
        .in_data                (in_data),
        .in_vld                 (in_vld),
        .in_ack                 (in_ack),
        .out_data               (out_data),
        .out_vld                (out_vld),
        .out_ack                (out_ack),
        .user_rst_n             (user_rst_n)
    );

    user_kernel user_kernel_i (
        .clk       (clk),
        .user_rst_n(user_rst_n),
        .in_data   (in_data),
        .in_vld    (in_vld),
        .in_ack    (in_ack),
        .out_data  (out_data),
        .out_vld   (out_vld),
        .out_ack   (out_ack)
    );

endmodule

// File: hdl/user_kernel.sv
`include "leaf_cfg.svh"

module user_kernel import leaf_pkg::*; (
    input  logic                            clk,
    input  logic                            user_rst_n,
    input  word_t [`LEAF_NUM_IN_PORTS-1:0]  in_data,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]   in_vld,
    output logic [`LEAF_NUM_IN_PORTS-1:0]   in_ack,
    output word_t [`LEAF_NUM_OUT_PORTS-1:0] out_data,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]  out_vld,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]  out_ack
);

    word_t       a;
    word_t       b;
    word_t       c;
    logic        free_ab;
    logic        free_c;
    logic        take_ab;
    logic        take_c;
    word_t [2:0] pair_q;       // sum, difference, maximum.
    logic [2:0]  pair_vld_q;
    word_t [2:0] strm_q;       // word, running sum, running count.
    logic [2:0]  strm_vld_q;
    word_t       sum_q;
    word_t       cnt_q;
    word_t       sum_next;
    word_t       cnt_next;

    assign a = in_data[0];
    assign b = in_data[1];
    assign c = in_data[2];

    // a group accepts new input only when every one of its results can be replaced.
    assign free_ab = &(~pair_vld_q | out_ack[2:0]);
    assign free_c  = &(~strm_vld_q | out_ack[5:3]);
    assign take_ab = in_vld[0] && in_vld[1] && free_ab;
    assign take_c  = in_vld[2] && free_c;

    assign in_ack   = {take_c, take_ab, take_ab};   // a and b leave as a pair.
    assign out_data = {strm_q, pair_q};
    assign out_vld  = {strm_vld_q, pair_vld_q};

    // ======================================================================
    // pairing group, outputs 1 to 3
    // ======================================================================

    always_ff @(posedge clk) begin
        if (take_ab) begin
            pair_q[0] <= a + b;
            pair_q[1] <= a - b;
            pair_q[2] <= (a > b) ? a : b;
        end
    end

    always_ff @(posedge clk) begin
        if (!user_rst_n) begin
            pair_vld_q <= '0;
        end else if (take_ab) begin
            pair_vld_q <= '1;
        end else begin
            pair_vld_q <= pair_vld_q & ~out_ack[2:0];
        end
    end

    // ======================================================================
    // stream group, outputs 4 to 6
    // ======================================================================

    assign sum_next = sum_q + c;       // wraps at 32 bits.
    assign cnt_next = cnt_q + 1'b1;

    always_ff @(posedge clk) begin
        if (take_c) begin
            strm_q[0] <= c;
            strm_q[1] <= sum_next;
            strm_q[2] <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!user_rst_n) begin
            strm_vld_q <= '0;
            sum_q      <= '0;
            cnt_q      <= '0;
        end else begin
            if (take_c) begin
                strm_vld_q <= '1;
                sum_q      <= sum_next;
                cnt_q      <= cnt_next;
            end else begin
                strm_vld_q <= strm_vld_q & ~out_ack[5:3];
            end
        end
    end

endmodule

// File: hdl/leaf_interface.sv
`include "leaf_cfg.svh"

module leaf_interface import leaf_pkg::*; #(
    parameter logic [`LEAF_ID_BITS-1:0] LEAF_ID = 5'd3
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  packet_t                         din_leaf_bft2interface,
    output packet_t                         dout_leaf_interface2bft,
    input  logic                            resend,
    input  logic                            ap_start,
    output word_t [`LEAF_NUM_IN_PORTS-1:0]  in_data,
    output logic [`LEAF_NUM_IN_PORTS-1:0]   in_vld,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]   in_ack,
    input  word_t [`LEAF_NUM_OUT_PORTS-1:0] out_data,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]  out_vld,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]  out_ack,
    output logic                            user_rst_n
);

    localparam int NUM_IN   = `LEAF_NUM_IN_PORTS;
    localparam int IDX_BITS = $clog2(`LEAF_NUM_OUT_PORTS + 1);

    logic [NUM_IN-1:0]   push;
    logic [NUM_IN-1:0]   full;
    word_t               push_data;
    logic                cfg_we;
    logic [IDX_BITS-1:0] cfg_idx;
    route_t              cfg_route;
    logic                started;

    // the kernel stays in reset until the first ap_start.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    assign user_rst_n = rst_n && started;

    leaf_rx #(
        .LEAF_ID(LEAF_ID)
    ) rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din_leaf_bft2interface),
        .full     (full),
        .push     (push),
        .push_data(push_data),
        .cfg_we   (cfg_we),
        .cfg_idx  (cfg_idx),
        .cfg_route(cfg_route)
    );

    for (genvar i = 0; i < NUM_IN; i++) begin : g_in_q
        leaf_fifo #(
            .item_t(word_t),
            .DEPTH (`LEAF_FIFO_DEPTH)
        ) in_q_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (push[i]),
            .push_data(push_data),
            .pop      (in_ack[i]),   // the kernel acks only a valid word.
            .full     (full[i]),
            .pop_data (in_data[i]),
            .pop_vld  (in_vld[i])
        );
    end

    leaf_tx tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .resend   (resend),
        .cfg_we   (cfg_we),
        .cfg_idx  (cfg_idx),
        .cfg_route(cfg_route),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_ack  (out_ack),
        .dout     (dout_leaf_interface2bft)
    );

endmodule

// File: hdl/leaf_tx.sv
`include "leaf_cfg.svh"

module leaf_tx import leaf_pkg::*; (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     resend,
    input  logic                                     cfg_we,
    input  logic [$clog2(`LEAF_NUM_OUT_PORTS+1)-1:0] cfg_idx,
    input  route_t                                   cfg_route,
    input  word_t [`LEAF_NUM_OUT_PORTS-1:0]          out_data,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]           out_vld,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]           out_ack,
    output packet_t                                  dout
);

    localparam int NUM_OUT   = `LEAF_NUM_OUT_PORTS;
    localparam int IDX_BITS  = $clog2(NUM_OUT + 1);
    localparam int ADDR_BITS = `LEAF_ADDR_BITS;

    route_t              route_tbl [NUM_OUT];
    logic [IDX_BITS-1:0] rr_last;   // port index of the last grant.
    logic [IDX_BITS-1:0] grant_idx;
    logic                found;
    logic                grant;
    packet_t             pkt_next;
    packet_t             pkt_q;

    // ======================================================================
    // route table
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OUT; i++) begin
                route_tbl[i] <= '0;
            end
        end else if (cfg_we && (cfg_idx != '0) && (cfg_idx <= NUM_OUT)) begin
            route_tbl[cfg_idx - 1'b1] <= cfg_route;   // entries are numbered from 1.
        end
    end

    // ======================================================================
    // round-robin arbiter
    // ======================================================================

    always_comb begin
        int cand;
        found     = 1'b0;
        grant_idx = '0;
        for (int i = 1; i <= NUM_OUT; i++) begin
            cand = (int'(rr_last) + i) % NUM_OUT;
            if (!found && out_vld[cand]) begin
                found     = 1'b1;
                grant_idx = IDX_BITS'(cand);
            end
        end
    end

    assign grant = found && !resend;   // resend freezes the arbiter too.

    always_comb begin
        out_ack = '0;
        if (grant) begin
            out_ack[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_last <= IDX_BITS'(NUM_OUT - 1);   // port 1 wins first.
        end else if (grant) begin
            rr_last <= grant_idx;
        end
    end

    // ======================================================================
    // outbound packet register
    // ======================================================================

    always_comb begin
        pkt_next           = '0;
        pkt_next.vld       = 1'b1;
        pkt_next.dest_leaf = route_tbl[grant_idx].leaf;
        pkt_next.dest_port = route_tbl[grant_idx].port;
        pkt_next.addr      = ADDR_BITS'(grant_idx) + 1'b1;
        pkt_next.payload   = out_data[grant_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q <= '0;
        end else if (!resend) begin
            pkt_q <= grant ? pkt_next : '0;   // a packet lasts one cycle.
        end
    end

    assign dout = resend ? '0 : pkt_q;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(out_ack));

endmodule

// File: hdl/leaf_rx.sv
`include "leaf_cfg.svh"

module leaf_rx import leaf_pkg::*; #(
    parameter logic [`LEAF_ID_BITS-1:0] LEAF_ID = 5'd3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  packet_t                             din,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       full,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       push,
    output word_t                               push_data,
    output logic                                cfg_we,
    output logic [$clog2(`LEAF_NUM_OUT_PORTS+1)-1:0] cfg_idx,
    output route_t                              cfg_route
);

    localparam int NUM_IN   = `LEAF_NUM_IN_PORTS;
    localparam int IDX_BITS = $clog2(`LEAF_NUM_OUT_PORTS + 1);

    logic              hit;
    logic              is_cfg;
    logic              is_data;
    logic [NUM_IN-1:0] want;

    // ======================================================================
    // address decode
    // ======================================================================

    assign hit     = din.vld && (din.dest_leaf == LEAF_ID);
    assign is_cfg  = hit && (din.dest_port == '0);
    assign is_data = hit && (din.dest_port != '0) && (din.dest_port <= NUM_IN);

    always_comb begin
        want = '0;
        for (int i = 0; i < NUM_IN; i++) begin
            if (is_data && (din.dest_port == `LEAF_PORT_BITS'(i + 1))) begin
                want[i] = 1'b1;   // data port n feeds queue n-1.
            end
        end
    end

    assign push      = want & ~full;   // a word for a full queue is lost.
    assign push_data = din.payload;

    // ======================================================================
    // route table writes
    // ======================================================================

    assign cfg_we    = is_cfg;
    assign cfg_idx   = din.addr[IDX_BITS-1:0];
    assign cfg_route = route_t'(din.payload[$bits(route_t)-1:0]);

    // only ports 0 to 3 exist on this leaf.
    assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> (din.dest_port <= NUM_IN));

    // flags a word dropped because its queue was full.
    assert property (@(posedge clk) disable iff (!rst_n)
        (want & full) == '0)
    else $warning("leaf_rx: input queue full, packet dropped");

endmodule

// File: hdl/leaf_fifo.sv
module leaf_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_data,
    input  logic  pop,
    output logic  full,
    output item_t pop_data,
    output logic  pop_vld
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;

    assign full     = (count == (PTR_BITS + 1)'(DEPTH));
    assign pop_vld  = (count != '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer checks full and the consumer acks only a valid word.
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> pop_vld);

endmodule

// File: hdl/leaf_pkg.sv
`include "leaf_cfg.svh"

package leaf_pkg;

    // one word on a user port.
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] word_t;

    // Destination of an outbound packet, as held in the route table.
    typedef struct packed {
        logic [`LEAF_ID_BITS-1:0]   leaf;   // destination leaf.
        logic [`LEAF_PORT_BITS-1:0] port;   // port on that leaf.
    } route_t;

    // packet on the tree bus, msb first.
    typedef struct packed {
        logic                       vld;
        logic [`LEAF_ID_BITS-1:0]   dest_leaf;
        logic [`LEAF_PORT_BITS-1:0] dest_port;
        logic [`LEAF_ADDR_BITS-1:0] addr;      // table index or user output port.
        word_t                      payload;
    } packet_t;

endpackage

// File: hdl/leaf_cfg.svh
`ifndef LEAF_CFG_SVH
`define LEAF_CFG_SVH

// ======================================================================
// packet format on the tree side
// ======================================================================

`define LEAF_PACKET_BITS 49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_ID_BITS 5
`define LEAF_PORT_BITS 4
`define LEAF_ADDR_BITS 7

// ======================================================================
// user side of the leaf
// ======================================================================

`define LEAF_NUM_IN_PORTS 3
`define LEAF_NUM_OUT_PORTS 6
`define LEAF_FIFO_DEPTH 4   // words per input queue.

`endif
